/* common/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// bus widths
`define DC_ADDR_W    32
`define DC_DATA_W    32

// 64 lines of 16 words
`define DC_INDEX_W   6
`define DC_OFFSET_W  4

// beats per line transfer
`define DC_BURST_LEN 16

// what is left of the address above index, offset and byte select
`define DC_TAG_W     (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W - 2)

`endif

/* common/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [`DC_DATA_W-1:0]   word_t;
    typedef logic [3:0]              byte_en_t;
    typedef logic [3:0]              axi_len_t;
    typedef logic [2:0]              axi_size_t;

    typedef logic [`DC_TAG_W-1:0]    dc_tag_t;
    typedef logic [`DC_INDEX_W-1:0]  dc_index_t;
    typedef logic [`DC_OFFSET_W-1:0] dc_offset_t;

    typedef struct packed {
        dc_tag_t    tag;
        dc_index_t  index;
        dc_offset_t offset;
        logic [1:0] bsel;
    } dc_addr_fields_t;

    // one address, either raw or split for the lookup
    typedef union packed {
        word_t           word;
        dc_addr_fields_t f;
    } dc_addr_u;

    typedef struct packed {
        dc_index_t  index;
        dc_offset_t offset;
    } dc_ram_addr_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_AR,
        S_R,
        S_FILL_END,
        S_AW,
        S_W,
        S_B
    } dc_state_e;

endpackage

/* common/dcache_tag_if.sv */
`timescale 1ns/10ps

interface dcache_tag_if;
    import dcache_pkg::*;

    // lookup result for the current request
    logic      hit;
    logic      victim_dirty;
    dc_tag_t   victim_tag;

    // line updates from the controller
    logic      fill_start;
    logic      fill_done;
    logic      wb_done;
    dc_index_t lock_index;

    modport tag_side (
        output hit, victim_dirty, victim_tag,
        input  fill_start, fill_done, wb_done, lock_index
    );

    modport ctrl_side (
        input  hit, victim_dirty, victim_tag,
        output fill_start, fill_done, wb_done, lock_index
    );

endinterface

/* common/dcache_fill_if.sv */
`timescale 1ns/10ps

interface dcache_fill_if;
    import dcache_pkg::*;

    logic         b_own;
    byte_en_t     b_wen;
    dc_ram_addr_t b_addr;
    word_t        b_wdata;
    // registered read data, shared by both ports
    word_t        dout;

    modport ram_side (
        input  b_own, b_wen, b_addr, b_wdata,
        output dout
    );

    modport ctrl_side (
        output b_own, b_wen, b_addr, b_wdata,
        input  dout
    );

endinterface

/* dcache/dcache_tag_store.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_tag_store (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 bus_en,
    input  logic                 bus_cached,
    input  dcache_pkg::dc_addr_u bus_addr,
    input  dcache_pkg::byte_en_t bus_wen,
    output dcache_pkg::byte_en_t hit_wen,
    dcache_tag_if.tag_side       tag
);
    import dcache_pkg::*;

    localparam int LINES = 1 << `DC_INDEX_W;

    dc_tag_t          tag_mem [LINES];
    logic [LINES-1:0] valid;
    logic [LINES-1:0] dirty;
    dc_index_t        idx;
    dc_tag_t          line_tag;

    assign idx      = bus_addr.f.index;
    assign line_tag = tag_mem[idx];

    assign tag.hit          = valid[idx] && (line_tag == bus_addr.f.tag);
    assign tag.victim_dirty = valid[idx] && dirty[idx] && !tag.hit;
    assign tag.victim_tag   = line_tag;

    // cpu may only write the ram on a cached hit
    assign hit_wen = (bus_en && bus_cached && tag.hit) ? bus_wen : '0;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (tag.fill_start) begin
                valid[idx] <= 1'b0;
            end
            if (tag.fill_done) begin
                valid[tag.lock_index] <= 1'b1;
            end
            if (tag.wb_done) begin
                dirty[tag.lock_index] <= 1'b0;
            end
            if (|hit_wen) begin
                dirty[idx] <= 1'b1;
            end
        end
    end

    // new tag goes in as soon as the fill is decided
    always_ff @(posedge aclk) begin
        if (tag.fill_start) begin
            tag_mem[idx] <= bus_addr.f.tag;
        end
    end

endmodule

/* dcache/dcache_data_ram.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_data_ram (
    input  logic                     aclk,
    input  dcache_pkg::dc_ram_addr_t a_addr,
    input  dcache_pkg::byte_en_t     a_wen,
    input  dcache_pkg::word_t        a_wdata,
    dcache_fill_if.ram_side          fill
);
    import dcache_pkg::*;

    localparam int DEPTH  = 1 << (`DC_INDEX_W + `DC_OFFSET_W);
    localparam int NBYTES = $bits(byte_en_t);

    word_t        mem [DEPTH];
    dc_ram_addr_t rd_addr;

    // controller takes the read port while it owns the line
    assign rd_addr = fill.b_own ? fill.b_addr : a_addr;

    always_ff @(posedge aclk) begin
        for (int i = 0; i < NBYTES; i++) begin
            if (a_wen[i]) begin
                mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
            end
            if (fill.b_wen[i]) begin
                mem[fill.b_addr][8*i +: 8] <= fill.b_wdata[8*i +: 8];
            end
        end
        fill.dout <= mem[rd_addr];
    end

endmodule

/* dcache/dcache_miss_ctrl.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_miss_ctrl (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  bus_en,
    input  logic                  bus_cached,
    input  dcache_pkg::dc_addr_u  bus_addr,
    input  dcache_pkg::byte_en_t  bus_wen,
    input  dcache_pkg::word_t     bus_wdata,
    input  logic [1:0]            bus_size,
    output dcache_pkg::word_t     bus_rdata,
    output logic                  bus_streq,
    output dcache_pkg::word_t     araddr,
    output dcache_pkg::axi_len_t  arlen,
    output dcache_pkg::axi_size_t arsize,
    output logic                  arvalid,
    input  logic                  arready,
    input  dcache_pkg::word_t     rdata,
    input  logic                  rlast,
    input  logic                  rvalid,
    output dcache_pkg::word_t     awaddr,
    output dcache_pkg::axi_len_t  awlen,
    output dcache_pkg::axi_size_t awsize,
    output logic                  awvalid,
    input  logic                  awready,
    output dcache_pkg::word_t     wdata,
    output dcache_pkg::byte_en_t  wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    dcache_tag_if.ctrl_side       tag,
    dcache_fill_if.ctrl_side      fill
);
    import dcache_pkg::*;

    localparam axi_len_t   LINE_LEN  = axi_len_t'(`DC_BURST_LEN - 1);
    localparam axi_size_t  WORD_SIZE = 3'b010;
    localparam dc_offset_t LAST_PREV = dc_offset_t'(`DC_BURST_LEN - 2);

    dc_state_e  state;
    dc_addr_u   lk_addr;
    logic       lk_cached;
    word_t      lk_data;
    byte_en_t   lk_strb;
    logic [1:0] lk_size;
    dc_offset_t cnt;
    dc_offset_t rd_off;
    word_t      uc_data;
    word_t      uc_addr;
    logic       uc_rdy;
    logic       uc_wdone;
    logic       rd_uc;
    logic       wr_req;
    logic       uc_hit;
    logic       rw_streq;
    dc_addr_u   line_addr;
    dc_addr_u   victim_addr;

    assign wr_req = |bus_wen;
    assign uc_hit = uc_rdy && (uc_addr == bus_addr.word);

    always_comb begin
        line_addr          = bus_addr;
        line_addr.f.offset = '0;
        line_addr.f.bsel   = '0;
        victim_addr        = line_addr;
        victim_addr.f.tag  = tag.victim_tag;
    end

    // stall until a hit, or until the uncached result is ready
    assign rw_streq  = bus_en && (bus_cached ? !tag.hit : (wr_req ? !uc_wdone : !uc_hit));
    assign bus_streq = rw_streq || fill.b_own;

    assign tag.fill_start = (state == S_IDLE) && bus_en && bus_cached
                            && !tag.hit && !tag.victim_dirty;
    assign tag.fill_done  = (state == S_FILL_END);
    assign tag.wb_done    = (state == S_B) && bvalid && lk_cached;
    assign tag.lock_index = lk_addr.f.index;

    // read one word ahead so dout follows each accepted W beat
    assign rd_off      = cnt + dc_offset_t'(wvalid && wready);
    assign fill.b_addr = {lk_addr.f.index, rd_off};

    assign araddr = lk_addr.word;
    assign awaddr = lk_addr.word;
    assign arlen  = lk_cached ? LINE_LEN : '0;
    assign awlen  = lk_cached ? LINE_LEN : '0;
    assign arsize = lk_cached ? WORD_SIZE : {1'b0, lk_size};
    assign awsize = lk_cached ? WORD_SIZE : {1'b0, lk_size};
    assign wstrb  = lk_cached ? '1 : lk_strb;
    assign wdata  = lk_cached ? fill.dout : lk_data;

    assign bus_rdata = rd_uc ? uc_data : fill.dout;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state      <= S_IDLE;
            lk_addr    <= '0;
            lk_cached  <= 1'b0;
            cnt        <= '0;
            arvalid    <= 1'b0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            wlast      <= 1'b0;
            fill.b_own <= 1'b0;
            fill.b_wen <= '0;
            uc_rdy     <= 1'b0;
            uc_wdone   <= 1'b0;
            rd_uc      <= 1'b0;
        end else begin
            fill.b_wen <= '0;
            uc_rdy     <= 1'b0;
            uc_wdone   <= 1'b0;
            // fill write address advances after each ram write
            if (|fill.b_wen) begin
                cnt <= cnt + 1'b1;
            end
            // remember where the completed read takes its data from
            if (bus_en && !bus_streq) begin
                rd_uc <= !bus_cached;
            end

            case (state)
                S_IDLE: begin
                    if (bus_en && bus_cached && !tag.hit) begin
                        lk_cached  <= 1'b1;
                        cnt        <= '0;
                        fill.b_own <= 1'b1;
                        if (tag.victim_dirty) begin
                            lk_addr <= victim_addr;
                            awvalid <= 1'b1;
                            state   <= S_AW;
                        end else begin
                            lk_addr <= line_addr;
                            arvalid <= 1'b1;
                            state   <= S_AR;
                        end
                    end else if (bus_en && !bus_cached && !wr_req && !uc_hit) begin
                        lk_cached <= 1'b0;
                        lk_addr   <= bus_addr;
                        arvalid   <= 1'b1;
                        state     <= S_AR;
                    end else if (bus_en && !bus_cached && wr_req && !uc_wdone) begin
                        lk_cached <= 1'b0;
                        lk_addr   <= bus_addr;
                        awvalid   <= 1'b1;
                        state     <= S_AW;
                    end
                end

                S_AR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= S_R;
                    end
                end

                S_R: begin
                    if (rvalid) begin
                        if (lk_cached) begin
                            fill.b_wen <= '1;
                        end
                        if (rlast && lk_cached) begin
                            state <= S_FILL_END;
                        end else if (rlast) begin
                            uc_rdy <= 1'b1;
                            state  <= S_IDLE;
                        end
                    end
                end

                // last word lands in the ram here
                S_FILL_END: begin
                    fill.b_own <= 1'b0;
                    state      <= S_IDLE;
                end

                S_AW: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                        wlast   <= !lk_cached;
                        state   <= S_W;
                    end
                end

                S_W: begin
                    if (wready && wlast) begin
                        wvalid <= 1'b0;
                        wlast  <= 1'b0;
                        state  <= S_B;
                    end else if (wready) begin
                        cnt   <= cnt + 1'b1;
                        wlast <= (cnt == LAST_PREV);
                    end
                end

                S_B: begin
                    if (bvalid && lk_cached) begin
                        fill.b_own <= 1'b0;
                        state      <= S_IDLE;
                    end else if (bvalid) begin
                        uc_wdone <= 1'b1;
                        state    <= S_IDLE;
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == S_IDLE && bus_en && !bus_cached) begin
            lk_data <= bus_wdata;
            lk_strb <= bus_wen;
            lk_size <= bus_size;
        end
        if (rvalid) begin
            fill.b_wdata <= rdata;
        end
        // kept until the next uncached read replaces it
        if (state == S_R && rvalid && !lk_cached) begin
            uc_data <= rdata;
            uc_addr <= lk_addr.word;
        end
    end

endmodule

/* source/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  bus_en,
    input  logic                  bus_cached,
    input  dcache_pkg::dc_addr_u  bus_addr,
    input  dcache_pkg::byte_en_t  bus_wen,
    input  dcache_pkg::word_t     bus_wdata,
    input  logic [1:0]            bus_size,
    output dcache_pkg::word_t     bus_rdata,
    output logic                  bus_streq,
    output dcache_pkg::word_t     araddr,
    output dcache_pkg::axi_len_t  arlen,
    output dcache_pkg::axi_size_t arsize,
    output logic                  arvalid,
    input  logic                  arready,
    input  dcache_pkg::word_t     rdata,
    input  logic                  rlast,
    input  logic                  rvalid,
    output dcache_pkg::word_t     awaddr,
    output dcache_pkg::axi_len_t  awlen,
    output dcache_pkg::axi_size_t awsize,
    output logic                  awvalid,
    input  logic                  awready,
    output dcache_pkg::word_t     wdata,
    output dcache_pkg::byte_en_t  wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid
);
    import dcache_pkg::*;

    byte_en_t hit_wen;

    dcache_tag_if  tag ();
    dcache_fill_if fill ();

    dcache_tag_store u_tags (.*);

    // cpu side of the ram, gated to cached hits
    dcache_data_ram u_ram (
        .aclk    (aclk),
        .a_addr  ({bus_addr.f.index, bus_addr.f.offset}),
        .a_wen   (hit_wen),
        .a_wdata (bus_wdata),
        .fill    (fill)
    );

    dcache_miss_ctrl u_ctrl (.*);

endmodule

/* verif/tb_axi_mem.sv */
`timescale 1ns/10ps

module tb_axi_mem (
    input  logic                  aclk,
    input  logic                  delay_en,
    input  dcache_pkg::word_t     araddr,
    input  dcache_pkg::axi_len_t  arlen,
    input  dcache_pkg::axi_size_t arsize,
    input  logic                  arvalid,
    output logic                  arready,
    output dcache_pkg::word_t     rdata,
    output logic                  rlast,
    output logic                  rvalid,
    input  dcache_pkg::word_t     awaddr,
    input  dcache_pkg::axi_len_t  awlen,
    input  dcache_pkg::axi_size_t awsize,
    input  logic                  awvalid,
    output logic                  awready,
    input  dcache_pkg::word_t     wdata,
    input  dcache_pkg::byte_en_t  wstrb,
    input  logic                  wlast,
    input  logic                  wvalid,
    output logic                  wready,
    output logic                  bvalid
);
    import dcache_pkg::*;

    word_t     mem [word_t];
    integer    seed = 32'hbcea;
    int        ar_count = 0;
    int        w_count = 0;
    int        ar_wmark = 0;
    int        proto_err = 0;
    axi_len_t  last_arlen;
    axi_size_t last_arsize;
    axi_size_t last_awsize;
    byte_en_t  last_wstrb;

    // untouched words hold a pattern of their own address
    function automatic word_t peek(word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return wa ^ 32'h5a5a0000;
    endfunction

    function automatic int gap();
        if (!delay_en) begin
            return 0;
        end
        return $random(seed) & 3;
    endfunction

    // read address and data channels
    initial begin
        word_t a;
        int    n;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        forever begin
            @(posedge aclk);
            #1;
            if (arvalid) begin
                a           = {araddr[31:2], 2'b00};
                n           = arlen;
                last_arlen  = arlen;
                last_arsize = arsize;
                ar_count++;
                ar_wmark = w_count;
                repeat (gap()) begin
                    @(posedge aclk);
                    #1;
                end
                arready = 1'b1;
                @(posedge aclk);
                #1;
                arready = 1'b0;
                for (int i = 0; i <= n; i++) begin
                    repeat (gap()) begin
                        @(posedge aclk);
                        #1;
                    end
                    rvalid = 1'b1;
                    rdata  = peek(a + 4 * i);
                    rlast  = (i == n);
                    @(posedge aclk);
                    #1;
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    // write address, data and response channels
    initial begin
        word_t a;
        word_t m;
        int    n;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            if (awvalid) begin
                a           = {awaddr[31:2], 2'b00};
                n           = awlen;
                last_awsize = awsize;
                repeat (gap()) begin
                    @(posedge aclk);
                    #1;
                end
                awready = 1'b1;
                @(posedge aclk);
                #1;
                awready = 1'b0;
                for (int i = 0; i <= n; i++) begin
                    repeat (gap()) begin
                        @(posedge aclk);
                        #1;
                    end
                    wready = 1'b1;
                    while (!wvalid) begin
                        @(posedge aclk);
                        #1;
                    end
                    if (wlast != (i == n)) begin
                        proto_err++;
                    end
                    m = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
                    mem[a + 4 * i] = (peek(a + 4 * i) & ~m) | (wdata & m);
                    last_wstrb = wstrb;
                    w_count++;
                    @(posedge aclk);
                    #1;
                    wready = 1'b0;
                end
                repeat (gap()) begin
                    @(posedge aclk);
                    #1;
                end
                bvalid = 1'b1;
                @(posedge aclk);
                #1;
                bvalid = 1'b0;
            end
        end
    end

endmodule

/* verif/tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache;
    import dcache_pkg::*;

    logic      aclk;
    logic      aresetn;
    logic      delay_en;
    logic      bus_en;
    logic      bus_cached;
    dc_addr_u  bus_addr;
    byte_en_t  bus_wen;
    word_t     bus_wdata;
    logic [1:0] bus_size;
    word_t     bus_rdata;
    logic      bus_streq;
    word_t     araddr;
    axi_len_t  arlen;
    axi_size_t arsize;
    logic      arvalid;
    logic      arready;
    word_t     rdata;
    logic      rlast;
    logic      rvalid;
    word_t     awaddr;
    axi_len_t  awlen;
    axi_size_t awsize;
    logic      awvalid;
    logic      awready;
    word_t     wdata;
    byte_en_t  wstrb;
    logic      wlast;
    logic      wvalid;
    logic      wready;
    logic      bvalid;

    dcache_top dut0 (.*);
    tb_axi_mem mem0 (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // the tests need a few microseconds even with delays
    initial begin
        #200000;
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    function automatic word_t pattern(word_t a);
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t nw, byte_en_t en);
        word_t r;
        r = old;
        for (int i = 0; i < 4; i++) begin
            if (en[i]) begin
                r[8*i +: 8] = nw[8*i +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_strb(input byte_en_t got, input byte_en_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // one cpu access, called and returning 1 ns after an edge
    task automatic cpu_access(input logic cached, input word_t addr, input byte_en_t wen,
                              input word_t data, output word_t rd, output int stalls);
        bus_en         = 1'b1;
        bus_cached     = cached;
        bus_addr.word  = addr;
        bus_wen        = wen;
        bus_wdata      = data;
        stalls         = 0;
        #1;
        while (bus_streq) begin
            @(posedge aclk);
            #2;
            stalls++;
        end
        @(posedge aclk);
        #1;
        bus_en  = 1'b0;
        bus_wen = '0;
        rd      = bus_rdata;
    endtask

    task automatic clean_miss(input word_t base);
        word_t rd;
        int    st;
        cpu_access(1'b1, base + 32'h14c, '0, '0, rd, st);
        check_word(rd, pattern(base + 32'h14c), "miss read data");
        check_word(word_t'(st > 0), 1, "miss stalled");
        for (int i = 0; i < 16; i++) begin
            if (i != 3) begin
                cpu_access(1'b1, base + 32'h140 + 4 * i, '0, '0, rd, st);
                check_word(rd, pattern(base + 32'h140 + 4 * i), "hit read data");
                check_word(word_t'(st), 0, "hit stall cycles");
            end
        end
    endtask

    task automatic write_hit(input word_t base);
        word_t rd;
        int    st;
        cpu_access(1'b1, base + 32'h148, 4'b0110, 32'hdeadbeef, rd, st);
        check_word(word_t'(st), 0, "write hit stall cycles");
        cpu_access(1'b1, base + 32'h148, '0, '0, rd, st);
        check_word(rd, merge_bytes(pattern(base + 32'h148), 32'hdeadbeef, 4'b0110),
                   "read after write hit");
    endtask

    task automatic dirty_miss(input word_t base);
        word_t rd;
        word_t a;
        int    st;
        int    w0;
        int    a0;
        w0 = mem0.w_count;
        a0 = mem0.ar_count;
        cpu_access(1'b1, base + 32'h40148, '0, '0, rd, st);
        check_word(rd, pattern(base + 32'h40148), "new line read data");
        check_word(word_t'(mem0.w_count - w0), 16, "writeback beats");
        check_word(word_t'(mem0.last_awsize), 2, "writeback awsize");
        check_word(word_t'(mem0.ar_count - a0), 1, "fill bursts");
        check_word(word_t'(mem0.ar_wmark), word_t'(w0 + 16), "writeback before fill");
        for (int i = 0; i < 16; i++) begin
            a = base + 32'h140 + 4 * i;
            if (i == 2) begin
                check_word(mem0.peek(a), merge_bytes(pattern(a), 32'hdeadbeef, 4'b0110),
                           "written back modified word");
            end else begin
                check_word(mem0.peek(a), pattern(a), "written back word");
            end
        end
    endtask

    task automatic uncached_read(input word_t base);
        word_t rd;
        int    st;
        int    a0;
        a0 = mem0.ar_count;
        // halfword size, so arsize has to follow bus_size
        bus_size = 2'b01;
        cpu_access(1'b0, base + 32'h2004, '0, '0, rd, st);
        check_word(rd, pattern(base + 32'h2004), "uncached read data");
        check_word(word_t'(mem0.last_arlen), 0, "uncached arlen");
        check_word(word_t'(mem0.last_arsize), 1, "uncached arsize");
        cpu_access(1'b0, base + 32'h2004, '0, '0, rd, st);
        bus_size = 2'b10;
        check_word(rd, pattern(base + 32'h2004), "repeated uncached read data");
        check_word(word_t'(mem0.ar_count - a0), 2, "uncached read bursts");
    endtask

    task automatic uncached_write(input word_t base);
        word_t rd;
        word_t a;
        word_t exp;
        int    st;
        int    a0;
        a   = base + 32'h3048;
        exp = merge_bytes(pattern(a), 32'h11223344, 4'b1100);
        bus_size = 2'b01;
        cpu_access(1'b0, a, 4'b1100, 32'h11223344, rd, st);
        bus_size = 2'b10;
        check_strb(mem0.last_wstrb, 4'b1100, "uncached wstrb");
        check_word(word_t'(mem0.last_awsize), 1, "uncached awsize");
        check_word(mem0.peek(a), exp, "memory after uncached write");
        cpu_access(1'b0, a, '0, '0, rd, st);
        check_word(rd, exp, "uncached read after write");
        a0 = mem0.ar_count;
        cpu_access(1'b1, a, '0, '0, rd, st);
        check_word(rd, exp, "cached read after uncached write");
        check_word(word_t'(mem0.ar_count - a0), 1, "cached read missed");
        check_word(word_t'(mem0.last_arlen), 15, "line fill arlen");
    endtask

    task automatic run_all(input word_t base);
        clean_miss(base);
        write_hit(base);
        dirty_miss(base);
        uncached_read(base);
        uncached_write(base);
    endtask

    initial begin
        aresetn    = 1'b0;
        delay_en   = 1'b0;
        bus_en     = 1'b0;
        bus_cached = 1'b0;
        bus_addr   = '0;
        bus_wen    = '0;
        bus_wdata  = '0;
        bus_size   = 2'b10;
        repeat (10) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(posedge aclk);
        #1;
        run_all(32'h0010_0000);
        // same checks with memory back-pressure
        delay_en = 1'b1;
        run_all(32'h0020_0000);
        check_word(word_t'(mem0.proto_err), 0, "wlast placement errors");
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* all.f */
+incdir+common
common/dcache_pkg.sv
common/dcache_tag_if.sv
common/dcache_fill_if.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_ram.sv
dcache/dcache_miss_ctrl.sv
source/dcache_top.sv
verif/tb_axi_mem.sv
verif/tb_dcache.sv
